//--- mem_config.svh
// Geometry, latency and size macros for the cache and banked memory
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Address and data widths
`define MEM_ADDR_W          16
`define MEM_DATA_W          16

// Address split: tag 15..11, index 10..3, word 2..1, byte 0
`define MEM_TAG_W           5
`define MEM_INDEX_W         8
`define MEM_WORDS_PER_LINE  4

// Sets per way
`define MEM_NUM_SETS        (1 << `MEM_INDEX_W)

// Main memory timing
`define MEM_READ_LAT        2
`define MEM_BANK_BUSY       4

// Bank is picked by the word select bits
`define MEM_NUM_BANKS       `MEM_WORDS_PER_LINE
// Word-addressed depth, byte bit dropped
`define MEM_NUM_WORDS       (1 << (`MEM_ADDR_W - 1))

`endif

//--- mem_pkg.sv
// Shared vector types, address fields, way and memory commands, controller states
`include "mem_config.svh"

package mem_pkg;

   typedef logic [`MEM_ADDR_W-1:0]                  addr_t;
   typedef logic [`MEM_DATA_W-1:0]                  word_t;
   typedef logic [`MEM_TAG_W-1:0]                   tag_t;
   typedef logic [`MEM_INDEX_W-1:0]                 index_t;
   typedef logic [$clog2(`MEM_WORDS_PER_LINE)-1:0]  word_sel_t;

   // Address viewed as its cache fields
   typedef struct packed {
      tag_t      tag;
      index_t    index;
      word_sel_t word_sel;
      logic      byte_sel;
   } addr_fields_t;

   // Controller command to one way
   typedef struct packed {
      logic      enable;
      logic      compare;
      logic      write;
      index_t    index;
      word_sel_t word_sel;
      tag_t      tag;
      word_t     data;
   } way_req_t;

   // Way answer for the addressed set and word
   typedef struct packed {
      logic  hit;
      logic  valid;
      logic  dirty;
      tag_t  tag_out;
      word_t data_out;
   } way_rsp_t;

   // Controller command to main memory
   typedef struct packed {
      logic  rd;
      logic  wr;
      addr_t addr;
      word_t data;
   } mem_req_t;

   typedef enum logic [2:0] {
      idle,
      compare,
      write_back,
      fill,
      finish_read,
      finish_write
   } ctrl_state_e;

endpackage

//--- cache_way.sv
// Cache way: per-set tag, valid and dirty bits with four-word line storage
`timescale 1ns/1ps
`include "mem_config.svh"

module cache_way (
   input  logic              clk,
   input  logic              rst,
   input  mem_pkg::way_req_t req,
   output mem_pkg::way_rsp_t rsp
);
   import mem_pkg::*;

   ////////////////////
   // Storage
   ////////////////////

   logic [`MEM_NUM_SETS-1:0] valid;
   logic [`MEM_NUM_SETS-1:0] dirty;
   tag_t                     tag_mem  [`MEM_NUM_SETS];
   word_t                    data_mem [`MEM_NUM_SETS][`MEM_WORDS_PER_LINE];

   logic tag_match;
   logic hit;
   logic cmp_wr;
   logic fill_wr;

   ////////////////////
   // Lookup
   ////////////////////

   assign tag_match = (tag_mem[req.index] == req.tag);

   // Hit only counts on an enabled compare access
   assign hit = req.enable & req.compare & valid[req.index] & tag_match;

   // Compare write lands only on a hit
   assign cmp_wr = hit & req.write;

   // Fill write from the controller, line becomes clean
   assign fill_wr = req.enable & ~req.compare & req.write;

   always_comb begin
      rsp.hit      = hit;
      rsp.valid    = valid[req.index];
      // Dirty means nothing on an invalid line
      rsp.dirty    = valid[req.index] & dirty[req.index];
      rsp.tag_out  = tag_mem[req.index];
      rsp.data_out = data_mem[req.index][req.word_sel];
   end

   ////////////////////
   // Update
   ////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         valid <= '0;
      end else if (fill_wr) begin
         valid[req.index] <= 1'b1;
      end
   end

   // Fill clears dirty, compare write sets it
   always_ff @(posedge clk) begin
      if (fill_wr) begin
         dirty[req.index] <= 1'b0;
      end else if (cmp_wr) begin
         dirty[req.index] <= 1'b1;
      end
   end

   // Tag follows the incoming line
   always_ff @(posedge clk) begin
      if (fill_wr) begin
         tag_mem[req.index] <= req.tag;
      end
   end

   // One word per cycle
   always_ff @(posedge clk) begin
      if (fill_wr || cmp_wr) begin
         data_mem[req.index][req.word_sel] <= req.data;
      end
   end

endmodule

//--- banked_mem.sv
// Four-bank word memory with fixed read latency and per-bank busy counters
`timescale 1ns/1ps
`include "mem_config.svh"

module banked_mem (
   input  logic              clk,
   input  logic              rst,
   input  mem_pkg::mem_req_t req,
   output mem_pkg::word_t    data_out,
   output logic              stall,
   output logic              err
);
   import mem_pkg::*;

   localparam int BUSY_W = $clog2(`MEM_BANK_BUSY);

   ////////////////////
   // State
   ////////////////////

   word_t mem [`MEM_NUM_WORDS];

   // Remaining busy cycles per bank
   logic [BUSY_W-1:0] busy_cnt [`MEM_NUM_BANKS];
   logic [`MEM_NUM_BANKS-1:0] busy;

   // Read data pipeline whose last stage drives data_out
   logic  rd_vld  [`MEM_READ_LAT];
   word_t rd_data [`MEM_READ_LAT];

   addr_fields_t                 req_f;
   logic [`MEM_ADDR_W-2:0]       word_addr;
   logic                         access;
   logic                         go;

   initial begin
      for (int i = 0; i < `MEM_NUM_WORDS; i++) begin
         mem[i] = '0;
      end
   end

   ////////////////////
   // Request decode
   ////////////////////

   assign req_f     = addr_fields_t'(req.addr);
   assign word_addr = req.addr[`MEM_ADDR_W-1:1];
   assign access    = req.rd | req.wr;

   always_comb begin
      for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
         busy[b] = (busy_cnt[b] != '0);
      end
   end

   // Both strobes or an odd address
   assign err   = (req.rd & req.wr) | (access & req_f.byte_sel);
   // Access to a busy bank is dropped
   assign stall = access & busy[req_f.word_sel];
   assign go    = access & ~err & ~stall;

   ////////////////////
   // Bank busy
   ////////////////////

   // Access cycle counts as the first busy cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
            if (go && (req_f.word_sel == b)) begin
               busy_cnt[b] <= BUSY_W'(`MEM_BANK_BUSY - 1);
            end else if (busy[b]) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   ////////////////////
   // Array access
   ////////////////////

   always_ff @(posedge clk) begin
      if (go && req.wr) begin
         mem[word_addr] <= req.data;
      end
   end

   // Read valid pipeline
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int s = 0; s < `MEM_READ_LAT; s++) begin
            rd_vld[s] <= 1'b0;
         end
      end else begin
         rd_vld[0] <= go & req.rd;
         for (int s = 1; s < `MEM_READ_LAT; s++) begin
            rd_vld[s] <= rd_vld[s-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      rd_data[0] <= mem[word_addr];
      for (int s = 1; s < `MEM_READ_LAT; s++) begin
         rd_data[s] <= rd_data[s-1];
      end
   end

   // Zero when no read lands this cycle
   assign data_out = rd_vld[`MEM_READ_LAT-1] ? rd_data[`MEM_READ_LAT-1] : '0;

endmodule

//--- cache_ctrl.sv
// Cache controller: request capture, hit check, LRU bits, write-back and fill sequencer
`timescale 1ns/1ps
`include "mem_config.svh"

module cache_ctrl (
   input  logic              clk,
   input  logic              rst,
   input  logic              rd,
   input  logic              wr,
   input  mem_pkg::addr_t    addr,
   input  mem_pkg::word_t    data_in,
   input  mem_pkg::way_rsp_t way0_rsp,
   input  mem_pkg::way_rsp_t way1_rsp,
   input  mem_pkg::word_t    mem_data,
   input  logic              mem_stall,
   input  logic              mem_err,
   output mem_pkg::way_req_t way0_req,
   output mem_pkg::way_req_t way1_req,
   output mem_pkg::mem_req_t mem_req,
   output mem_pkg::word_t    data_out,
   output logic              done,
   output logic              stall,
   output logic              cache_hit,
   output logic              err
);
   import mem_pkg::*;

   ctrl_state_e state, next_state;
   logic [2:0]  step;

   // Captured request
   addr_t        req_addr;
   word_t        req_data;
   logic         req_wr;
   addr_fields_t req_f;

   logic [`MEM_NUM_SETS-1:0] lru;
   logic                     victim, victim_q, victim_dirty;
   way_rsp_t                 victim_rsp;
   way_req_t                 way_cmd;
   logic                     en0, en1;
   logic                     hit, accept, req_err;
   logic                     lru_upd, lru_val;

   ////////////////////
   // Request capture
   ////////////////////

   // Exactly one strobe and an even address
   assign accept  = (state == idle) & (rd ^ wr) & ~addr[0];
   assign req_err = (state == idle) & (rd | wr) & ((rd & wr) | addr[0]);

   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr <= addr;
         req_data <= data_in;
         req_wr   <= wr;
      end
   end

   assign req_f = addr_fields_t'(req_addr);

   ////////////////////
   // Hit and victim
   ////////////////////

   assign hit = way0_rsp.hit | way1_rsp.hit;

   // Invalid way first, way 0 before way 1, else LRU
   assign victim       = ~way0_rsp.valid ? 1'b0 :
                         ~way1_rsp.valid ? 1'b1 : lru[req_f.index];
   assign victim_dirty = victim ? way1_rsp.dirty : way0_rsp.dirty;
   assign victim_rsp   = victim_q ? way1_rsp : way0_rsp;

   assign stall = (state != idle);
   // Memory stall means the sequencer broke bank order
   assign err   = req_err | mem_stall | mem_err;

   always_comb begin
      next_state       = state;
      way_cmd          = '0;
      way_cmd.index    = req_f.index;
      way_cmd.word_sel = req_f.word_sel;
      way_cmd.tag      = req_f.tag;
      way_cmd.data     = req_data;
      en0              = 1'b0;
      en1              = 1'b0;
      mem_req          = '0;
      data_out         = '0;
      done             = 1'b0;
      cache_hit        = 1'b0;
      lru_upd          = 1'b0;
      lru_val          = 1'b0;
      case (state)
         idle: begin
            if (accept) next_state = compare;
         end
         compare: begin
            // Both ways look, only a hitting way writes
            en0             = 1'b1;
            en1             = 1'b1;
            way_cmd.compare = 1'b1;
            way_cmd.write   = req_wr;
            if (hit) begin
               done      = 1'b1;
               cache_hit = 1'b1;
               if (!req_wr) data_out = way0_rsp.hit ? way0_rsp.data_out : way1_rsp.data_out;
               // Other way becomes LRU
               lru_upd    = 1'b1;
               lru_val    = way0_rsp.hit;
               next_state = idle;
            end else begin
               next_state = victim_dirty ? write_back : fill;
            end
         end
         write_back: begin
            // Old line out, banks 0 to 3
            en0              = ~victim_q;
            en1              = victim_q;
            way_cmd.word_sel = step[1:0];
            mem_req.wr       = 1'b1;
            mem_req.addr     = {victim_rsp.tag_out, req_f.index, step[1:0], 1'b0};
            mem_req.data     = victim_rsp.data_out;
            if (step == 3'd3) next_state = fill;
         end
         fill: begin
            // Reads in steps 0..3, data lands two steps later
            mem_req.rd   = ~step[2];
            mem_req.addr = {req_f.tag, req_f.index, step[1:0], 1'b0};
            if (step >= 3'd2) begin
               en0              = ~victim_q;
               en1              = victim_q;
               way_cmd.write    = 1'b1;
               way_cmd.word_sel = step[1:0] - 2'd2;
               way_cmd.data     = mem_data;
            end
            if (step == 3'd5) next_state = req_wr ? finish_write : finish_read;
         end
         finish_read: begin
            en0        = ~victim_q;
            en1        = victim_q;
            done       = 1'b1;
            data_out   = victim_rsp.data_out;
            lru_upd    = 1'b1;
            lru_val    = ~victim_q;
            next_state = idle;
         end
         finish_write: begin
            // Compare write marks the new line dirty
            en0             = ~victim_q;
            en1             = victim_q;
            way_cmd.compare = 1'b1;
            way_cmd.write   = 1'b1;
            done            = 1'b1;
            lru_upd         = 1'b1;
            lru_val         = ~victim_q;
            next_state      = idle;
         end
         default: next_state = idle;
      endcase
   end

   always_comb begin
      way0_req        = way_cmd;
      way0_req.enable = en0;
      way1_req        = way_cmd;
      way1_req.enable = en1;
   end

   ////////////////////
   // Registers
   ////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= idle;
         step     <= '0;
         victim_q <= 1'b0;
         lru      <= '0;
      end else begin
         state <= next_state;
         // Step runs only inside the two line sequences
         if ((state == write_back || state == fill) && next_state == state) begin
            step <= step + 1'b1;
         end else begin
            step <= '0;
         end
         if (state == compare) victim_q <= victim;
         if (lru_upd) lru[req_f.index] <= lru_val;
      end
   end

endmodule

//--- mem_system.sv
// Top level: controller, two cache ways and banked main memory
`timescale 1ns/1ps

module mem_system (
   input  logic           clk,
   input  logic           rst,
   input  logic           rd,
   input  logic           wr,
   input  mem_pkg::addr_t addr,
   input  mem_pkg::word_t data_in,
   output mem_pkg::word_t data_out,
   output logic           done,
   output logic           stall,
   output logic           cache_hit,
   output logic           err
);
   import mem_pkg::*;

   // Controller to ways
   way_req_t way0_req;
   way_req_t way1_req;
   way_rsp_t way0_rsp;
   way_rsp_t way1_rsp;

   // Controller to memory
   mem_req_t mem_req;
   word_t    mem_data;
   logic     mem_stall;
   logic     mem_err;

   cache_ctrl i_ctrl (
      .clk       (clk),
      .rst       (rst),
      .rd        (rd),
      .wr        (wr),
      .addr      (addr),
      .data_in   (data_in),
      .way0_rsp  (way0_rsp),
      .way1_rsp  (way1_rsp),
      .mem_data  (mem_data),
      .mem_stall (mem_stall),
      .mem_err   (mem_err),
      .way0_req  (way0_req),
      .way1_req  (way1_req),
      .mem_req   (mem_req),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   // Two identical ways
   cache_way i_way0 (.clk(clk), .rst(rst), .req(way0_req), .rsp(way0_rsp));
   cache_way i_way1 (.clk(clk), .rst(rst), .req(way1_req), .rsp(way1_rsp));

   banked_mem i_mem (
      .clk      (clk),
      .rst      (rst),
      .req      (mem_req),
      .data_out (mem_data),
      .stall    (mem_stall),
      .err      (mem_err)
   );

endmodule

//--- mem_system_properties.sv
// Handshake assertions bound into the memory system top level
`timescale 1ns/1ps

module mem_system_properties (
   input logic clk,
   input logic rst,
   input logic done,
   input logic stall,
   input logic cache_hit,
   input logic err
);

   // Failed assertions so far
   int unsigned fail_count = 0;

   // Consecutive stall cycles so far
   logic [4:0] stall_run;

   always_ff @(posedge clk) begin
      if (rst) begin
         stall_run <= '0;
      end else if (stall) begin
         stall_run <= stall_run + 5'd1;
      end else begin
         stall_run <= '0;
      end
   end

   ////////////////////
   // Properties
   ////////////////////

   a_done_in_stall: assert property (@(posedge clk) disable iff (rst) done |-> stall)
      else begin
         fail_count++;
         $error("done high while stall is low");
      end

   a_done_no_err: assert property (@(posedge clk) disable iff (rst) !(done && err))
      else begin
         fail_count++;
         $error("done and err high together");
      end

   a_hit_with_done: assert property (@(posedge clk) disable iff (rst) cache_hit |-> done)
      else begin
         fail_count++;
         $error("cache_hit high without done");
      end

   // Longest sequence is a dirty miss of twelve stall cycles
   a_stall_bound: assert property (@(posedge clk) disable iff (rst) stall |-> (stall_run < 5'd12))
      else begin
         fail_count++;
         $error("stall held high for more than 12 cycles");
      end

endmodule

bind mem_system mem_system_properties i_props (
   .clk       (clk),
   .rst       (rst),
   .done      (done),
   .stall     (stall),
   .cache_hit (cache_hit),
   .err       (err)
);

//--- tb_mem_system.sv
// Memory system testbench with clock, reset, directed and random requests, model and watchdog
`timescale 1ns/1ps
`include "mem_config.svh"

module tb_mem_system;
   import mem_pkg::*;

   localparam int          CLK_PERIOD = 40;
   localparam int          NUM_REQ    = 600;
   localparam int          NUM_DIR    = 13;
   localparam int          MAX_LAT    = 14;
   localparam int          DONE_LIMIT = 16;
   localparam logic [31:0] SEED       = 32'h50c1;
   // Set shared by the directed eviction sequence
   localparam index_t      DIR_SET    = 8'h15;

   logic  clk;
   logic  rst;
   logic  rd;
   logic  wr;
   addr_t addr;
   word_t data_in;
   word_t data_out;
   logic  done;
   logic  stall;
   logic  cache_hit;
   logic  err;

   ////////////////////
   // Reference model
   ////////////////////

   // CPU view of memory plus cache bookkeeping per way and set
   word_t model_mem   [`MEM_NUM_WORDS];
   tag_t  model_tag   [2][`MEM_NUM_SETS];
   logic  model_valid [2][`MEM_NUM_SETS];
   logic  model_dirty [2][`MEM_NUM_SETS];
   // Set means way 1 is least recently used
   logic  model_lru   [`MEM_NUM_SETS];

   int errors;
   int n_hit;
   int n_clean_miss;
   int n_dirty_miss;
   int n_rejected;

   mem_system i_dut (
      .clk       (clk),
      .rst       (rst),
      .rd        (rd),
      .wr        (wr),
      .addr      (addr),
      .data_in   (data_in),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////
   // Compare tasks
   ////////////////////

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   // Cycles from acceptance to done
   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         errors++;
         $display("FAIL at %0t: %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   ////////////////////
   // Model update
   ////////////////////

   // Expected latency, hit flag and read word; model moves to the state after the request
   task automatic predict(input logic r, input logic w, input addr_t a, input word_t d,
                          output int lat, output logic hit_o, output word_t rdata);
      addr_fields_t f;
      int           way;
      int           victim;
      int           i;
      f      = addr_fields_t'(a);
      way    = -1;
      rdata  = model_mem[a[15:1]];
      for (i = 0; i < 2; i++) begin
         if (model_valid[i][f.index] && model_tag[i][f.index] == f.tag) way = i;
      end
      if (way >= 0) begin
         lat   = 1;
         hit_o = 1'b1;
         n_hit++;
         if (w) model_dirty[way][f.index] = 1'b1;
         model_lru[f.index] = (way == 0);
      end else begin
         // Invalid way first, then the LRU way
         if (!model_valid[0][f.index]) victim = 0;
         else if (!model_valid[1][f.index]) victim = 1;
         else victim = model_lru[f.index] ? 1 : 0;
         hit_o = 1'b0;
         if (model_valid[victim][f.index] && model_dirty[victim][f.index]) begin
            lat = 12;
            n_dirty_miss++;
         end else begin
            lat = 8;
            n_clean_miss++;
         end
         model_tag[victim][f.index]   = f.tag;
         model_valid[victim][f.index] = 1'b1;
         model_dirty[victim][f.index] = w;
         model_lru[f.index]           = (victim == 0);
      end
      if (w) model_mem[a[15:1]] = d;
   endtask

   ////////////////////
   // Request driver
   ////////////////////

   task automatic run_request(input logic r, input logic w, input addr_t a, input word_t d);
      logic  bad;
      int    exp_lat;
      logic  exp_hit;
      word_t exp_data;
      int    lat;
      int    wait_cnt;
      bad      = (r & w) | a[0];
      wait_cnt = 0;
      @(posedge clk);
      #2;
      while (stall && wait_cnt < DONE_LIMIT) begin
         @(posedge clk);
         #2;
         wait_cnt++;
      end
      if (stall) begin
         errors++;
         $display("ERROR at %0t: stall stayed high, request could not be issued", $time);
      end
      if (bad) begin
         n_rejected++;
      end else begin
         predict(r, w, a, d, exp_lat, exp_hit, exp_data);
      end
      rd      = r;
      wr      = w;
      addr    = a;
      data_in = d;
      @(negedge clk);
      check_bit("err", err, bad);
      check_bit("done", done, 1'b0);
      @(posedge clk);
      #2;
      // Scrambled inputs test that the DUT holds its own copy
      rd      = 1'b0;
      wr      = 1'b0;
      addr    = addr_t'($urandom);
      data_in = word_t'($urandom);
      @(negedge clk);
      if (bad) begin
         check_bit("stall", stall, 1'b0);
         check_bit("done", done, 1'b0);
      end else begin
         lat = 1;
         while (!done && lat < DONE_LIMIT) begin
            check_bit("err", err, 1'b0);
            @(negedge clk);
            lat++;
         end
         if (!done) begin
            errors++;
            $display("ERROR at %0t: no done within %0d cycles of address %h",
                     $time, DONE_LIMIT, a);
         end else begin
            check_count("latency", lat, exp_lat);
            check_bit("cache_hit", cache_hit, exp_hit);
            check_bit("err", err, 1'b0);
            if (r) check_word("data_out", data_out, exp_data);
         end
      end
   endtask

   // Four tags over three sets keep both ways busy with evictions
   task automatic random_request();
      int        kind;
      tag_t      t;
      index_t    s;
      word_sel_t ws;
      logic      r;
      logic      w;
      logic      odd;
      kind = $urandom_range(0, 39);
      t    = tag_t'($urandom_range(0, 3));
      s    = index_t'($urandom_range(0, 2) * 8'h51);
      ws   = word_sel_t'($urandom_range(0, 3));
      r    = 1'($urandom_range(0, 1));
      w    = ~r;
      odd  = 1'b0;
      if (kind == 0) begin
         r = 1'b1;
         w = 1'b1;
      end else if (kind == 1) begin
         odd = 1'b1;
      end
      run_request(r, w, {t, s, ws, odd}, word_t'($urandom));
   endtask

   function automatic addr_t make_addr(input tag_t t, input word_sel_t ws);
      return {t, DIR_SET, ws, 1'b0};
   endfunction

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      errors       = 0;
      n_hit        = 0;
      n_clean_miss = 0;
      n_dirty_miss = 0;
      n_rejected   = 0;
      rst          = 1'b1;
      rd           = 1'b0;
      wr           = 1'b0;
      addr         = '0;
      data_in      = '0;
      void'($urandom(SEED));
      for (int i = 0; i < `MEM_NUM_WORDS; i++) model_mem[i] = '0;
      for (int s = 0; s < `MEM_NUM_SETS; s++) begin
         model_valid[0][s] = 1'b0;
         model_valid[1][s] = 1'b0;
         model_dirty[0][s] = 1'b0;
         model_dirty[1][s] = 1'b0;
         model_lru[s]      = 1'b0;
      end
      repeat (3) @(posedge clk);
      #2;
      rst = 1'b0;
      @(negedge clk);
      check_bit("stall", stall, 1'b0);
      check_bit("done", done, 1'b0);
      check_bit("cache_hit", cache_hit, 1'b0);
      check_bit("err", err, 1'b0);

      // Dirty line, LRU choice among three tags, write-back, then errors
      run_request(1'b0, 1'b1, make_addr(5'd1, 2'd0), 16'h1111);
      run_request(1'b1, 1'b0, make_addr(5'd2, 2'd1), 16'h0000);
      run_request(1'b1, 1'b0, make_addr(5'd1, 2'd0), 16'h0000);
      run_request(1'b1, 1'b0, make_addr(5'd3, 2'd2), 16'h0000);
      run_request(1'b1, 1'b0, make_addr(5'd1, 2'd0), 16'h0000);
      run_request(1'b1, 1'b0, make_addr(5'd2, 2'd1), 16'h0000);
      run_request(1'b1, 1'b0, make_addr(5'd3, 2'd2), 16'h0000);
      run_request(1'b1, 1'b0, make_addr(5'd1, 2'd0), 16'h0000);
      run_request(1'b0, 1'b1, make_addr(5'd1, 2'd3), 16'hbeef);
      run_request(1'b1, 1'b0, make_addr(5'd1, 2'd3), 16'h0000);
      run_request(1'b1, 1'b1, make_addr(5'd1, 2'd3), 16'h5555);
      run_request(1'b1, 1'b0, make_addr(5'd1, 2'd3) | 16'h0001, 16'h0000);
      // Rejected write above must leave the stored word alone
      run_request(1'b1, 1'b0, make_addr(5'd1, 2'd3), 16'h0000);

      // Kind counts below cover the random phase only
      n_hit        = 0;
      n_clean_miss = 0;
      n_dirty_miss = 0;
      n_rejected   = 0;
      for (int n = 0; n < NUM_REQ; n++) random_request();

      if (n_hit == 0 || n_clean_miss == 0 || n_dirty_miss == 0 || n_rejected == 0) begin
         errors++;
         $display("ERROR: random stimulus missed a request kind (hit, clean miss, dirty miss, error)");
      end
      errors += int'(i_dut.i_props.fail_count);
      $write("Done: %0d random requests, %0d hits, %0d clean misses, ",
             NUM_REQ, n_hit, n_clean_miss);
      $display("%0d dirty misses, %0d rejected, %0d errors",
               n_dirty_miss, n_rejected, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   // Worst case per request plus reset and slack
   initial begin
      #(CLK_PERIOD * ((NUM_REQ + NUM_DIR) * MAX_LAT + 100));
      $display("ERROR: watchdog expired before all requests finished");
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

//--- compile.f
+incdir+.
mem_pkg.sv
cache_way.sv
banked_mem.sv
cache_ctrl.sv
mem_system.sv
mem_system_properties.sv
tb_mem_system.sv

//--- Makefile
# Verilator build and run for the memory system testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_system
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= SIMULATION PASSED

SOURCES := $(wildcard *.sv) $(wildcard *.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run check clean

all: check

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

check: run
	@grep -q "$(PASS_MSG)" $(LOG) && echo "check: pass message found" || \
		(echo "check: pass message missing in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
